// File: char_link_if.sv
// one character at a time; source holds data stable until word_finished is seen
`timescale 1ns/1ps
`default_nettype none

interface char_link_if import echo_pkg::*; ();

	// request from the formatter
	logic enable;
	logic [char_bits-1:0] data;

	// status from the transmitter
	logic ready;
	logic word_finished;

	// formatter side
	modport source (
		output enable, data,
		input ready, word_finished
	);

	// transmitter side
	modport sink (
		input enable, data,
		output ready, word_finished
	);

endinterface

`default_nettype wire

// File: echo_formatter.sv
// one char in, twelve out; receiver is held off for the whole reply so chars sent then are lost
`timescale 1ns/1ps
`default_nettype none

module echo_formatter import echo_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic [char_bits-1:0] rx_char,
	input logic rx_done,
	output logic rx_enable,
	char_link_if.source link
);

	echo_state_t state_q;
	echo_state_t state_d;
	logic [char_idx_w-1:0] bit_idx_q;
	logic [char_idx_w-1:0] bit_idx_d;
	logic [char_bits-1:0] char_q;

	// listen only while idle
	assign rx_enable = state_q == wait_rx;

	// request drops in the word_finished cycle
	assign link.enable = state_q != wait_rx && !link.word_finished;

	// captured character
	always_ff @(posedge clk27) begin
		if (state_q == wait_rx && rx_done) begin
			char_q <= rx_char;
		end
	end

	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state_q <= wait_rx;
			bit_idx_q <= char_idx_w'(char_bits - 1);
		end else begin
			state_q <= state_d;
			bit_idx_q <= bit_idx_d;
		end
	end

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		bit_idx_d = bit_idx_q;
		case (state_q)
			wait_rx: begin
				if (rx_done) begin
					state_d = send_char;
				end
			end
			send_char: begin
				if (link.word_finished) begin
					state_d = send_space;
				end
			end
			send_space: begin
				// bits go out msb first
				if (link.word_finished) begin
					state_d = send_bit;
					bit_idx_d = char_idx_w'(char_bits - 1);
				end
			end
			send_bit: begin
				if (link.word_finished) begin
					if (bit_idx_q == '0) begin
						state_d = send_cr;
					end else begin
						bit_idx_d = bit_idx_q - 1'b1;
					end
				end
			end
			send_cr: begin
				if (link.word_finished) begin
					state_d = send_nl;
				end
			end
			send_nl: begin
				if (link.word_finished) begin
					state_d = wait_rx;
				end
			end
			default: state_d = wait_rx;
		endcase
	end

	// character on the link, by state
	always_comb begin
		case (state_q)
			send_char: link.data = char_q;
			send_bit: link.data = char_q[bit_idx_q] ? ascii_one : ascii_zero;
			send_cr: link.data = ascii_cr;
			send_nl: link.data = ascii_lf;
			default: link.data = ascii_space;
		endcase
	end

endmodule

`default_nettype wire

// File: echo_pkg.sv
// constants assume a 27 MHz clock and 115200 baud; debounce_clks is shortened for simulation
`default_nettype none

package echo_pkg;

	// ------------------------------------------------------------
	// board and serial line
	// ------------------------------------------------------------
	localparam int unsigned clk_hz = 27_000_000;
	localparam int unsigned baud = 115_200;

	// rounded cycles per serial bit, 234 here
	localparam int unsigned clks_per_bit = (clk_hz + baud / 2) / baud;
	localparam int unsigned baud_cnt_w = $clog2(clks_per_bit);

	// receiver oversampling
	localparam int unsigned oversample = 16;
	localparam int unsigned sample_point = 8;
	localparam int unsigned tick_w = $clog2(oversample);

	// character framing, 8N1
	localparam int unsigned char_bits = 8;
	localparam int unsigned char_idx_w = $clog2(char_bits);
	localparam int unsigned frame_bits = char_bits + 2;
	localparam int unsigned frame_idx_w = $clog2(frame_bits);

	// stable cycles before a key level is taken, about 27000 on the board
	localparam int unsigned debounce_clks = 64;
	localparam int unsigned db_cnt_w = $clog2(debounce_clks + 1);

	// ascii codes used in the reply
	localparam logic [char_bits-1:0] ascii_space = 8'h20;
	localparam logic [char_bits-1:0] ascii_cr = 8'h0d;
	localparam logic [char_bits-1:0] ascii_lf = 8'h0a;
	localparam logic [char_bits-1:0] ascii_zero = 8'h30;
	localparam logic [char_bits-1:0] ascii_one = 8'h31;

	// ------------------------------------------------------------
	// echo formatter states
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		wait_rx, send_char, send_space, send_bit, send_cr, send_nl
	} echo_state_t;

endpackage

`default_nettype wire

// File: echo_stimulus.txt
# c: char (hex), idle bits before it (hex); o: char (hex), char sent mid reply (hex)
# k: key number, expected led[2:1] after the release (hex)
c 41 2
c 7a 0
c 00 0
o 55 4e
c 4f 14
k 1 1
k 1 3
k 0 3
k 1 1
c ff 1
c a5 4

// File: flist.f
echo_pkg.sv
char_link_if.sv
uart_tx.sv
uart_rx.sv
key_debounce.sv
echo_formatter.sv
serial_echo_top.sv
tb_serial_echo.sv

// File: key_debounce.sv
// key_n is active low and asynchronous; outputs lag a settled key by about debounce_clks cycles
`timescale 1ns/1ps
`default_nettype none

module key_debounce import echo_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic key_n,
	output logic level,
	output logic toggled
);

	logic [1:0] sync;
	logic pressed;
	logic [db_cnt_w-1:0] cnt;

	// high while held
	assign pressed = ~sync[1];

	// ------------------------------------------------------------
	// sync, stability counter, press toggle
	// ------------------------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			sync <= 2'b11;
			cnt <= '0;
			level <= 1'b0;
			toggled <= 1'b0;
		end else begin
			sync <= {sync[0], key_n};
			if (pressed == level) begin
				// bounce back, start over
				cnt <= '0;
			end else if (cnt == db_cnt_w'(debounce_clks)) begin
				cnt <= '0;
				level <= pressed;
				// flip once per accepted press
				if (pressed) begin
					toggled <= ~toggled;
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: serial_echo_top.sv
// keys and leds are active low; reset_request is only an output and resets nothing in here
`timescale 1ns/1ps
`default_nettype none

module serial_echo_top import echo_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic serial_rx,
	output logic serial_tx,
	input logic [1:0] key,
	output logic [5:0] led,
	output logic reset_request
);

	logic key0_level;
	logic key1_toggled;
	logic [char_bits-1:0] rx_char;
	logic rx_done;
	logic rx_enable;

	char_link_if link ();

	// ------------------------------------------------------------
	// keys
	// ------------------------------------------------------------
	key_debounce u_key0 (.clk27, .rst, .key_n(key[0]), .level(key0_level), .toggled());
	key_debounce u_key1 (.clk27, .rst, .key_n(key[1]), .level(), .toggled(key1_toggled));

	// ------------------------------------------------------------
	// serial path
	// ------------------------------------------------------------
	uart_rx u_rx (
		.clk27, .rst, .enable(rx_enable), .serial_rx,
		.char(rx_char), .word_finished(rx_done)
	);

	echo_formatter u_fmt (.clk27, .rst, .rx_char, .rx_done, .rx_enable, .link(link.source));

	uart_tx u_tx (.clk27, .rst, .link(link.sink), .serial_tx);

	// board reset logic takes this
	assign reset_request = key0_level;

	// leds, low is lit
	assign led[0] = 1'b1;
	assign led[1] = ~key0_level;
	assign led[2] = ~key1_toggled;
	assign led[5:3] = 3'b111;

endmodule

`default_nettype wire

// File: tb_serial_echo.sv
// needs echo_stimulus.txt in the working directory; the clock period here is 10 ns, not the board's
`timescale 1ns/1ps
`default_nettype none

module tb_serial_echo import echo_pkg::*; ();

	logic clk27;
	logic rst;
	logic serial_rx;
	logic serial_tx;
	logic [1:0] key;
	logic [5:0] led;
	logic reset_request;

	// decoded reply characters, oldest first
	logic [7:0] rx_q [$];

	// records from the stimulus file
	logic [7:0] kinds [0:31];
	logic [7:0] arg_a [0:31];
	logic [7:0] arg_b [0:31];
	int n_rec = 0;
	bit loaded = 1'b0;

	int checks = 0;
	int errors = 0;

	serial_echo_top UUT (
		.clk27, .rst, .serial_rx, .serial_tx, .key, .led, .reset_request
	);

	initial begin
		clk27 = 1'b0;
		forever #5 clk27 = ~clk27;
	end

	// ------------------------------------------------------------
	// expected reply and serial encoder
	// ------------------------------------------------------------

	// char, space, msb..lsb as ascii, cr, lf
	function automatic logic [7:0] reply_char(input logic [7:0] c, input int pos);
		if (pos == 0) return c;
		if (pos == 1) return 8'h20;
		if (pos <= 9) return c[9 - pos] ? "1" : "0";
		if (pos == 10) return 8'h0d;
		return 8'h0a;
	endfunction

	task automatic idle_bits(input int n);
		repeat (n * clks_per_bit) @(posedge clk27);
	endtask

	// start, data lsb first, stop
	task automatic send_serial_char(input logic [7:0] c);
		logic [9:0] frame;
		frame = {1'b1, c, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk27);
			serial_rx <= frame[i];
			repeat (clks_per_bit - 1) @(posedge clk27);
		end
	endtask

	task automatic wait_for_chars(input int n, output bit ok);
		int waited;
		waited = 0;
		while (rx_q.size() < n && waited < 14 * 10 * clks_per_bit) begin
			@(posedge clk27);
			waited++;
		end
		ok = rx_q.size() >= n;
		if (!ok) begin
			errors++;
			$display("no reply: only %0d of %0d characters arrived in time", rx_q.size(), n);
		end
	endtask

	task automatic check_reply(input logic [7:0] c, input string name);
		logic [7:0] exp;
		logic [7:0] act;
		bit ok;
		wait_for_chars(12, ok);
		if (ok) begin
			for (int i = 0; i < 12; i++) begin
				exp = reply_char(c, i);
				act = rx_q.pop_front();
				checks++;
				if (act !== exp) begin
					errors++;
					$display("MISMATCH %s pos %0d expected %h actual %h", name, i, exp, act);
				end
			end
		end
		// rest of the last stop bit, formatter back in wait_rx
		idle_bits(1);
	endtask

	// ------------------------------------------------------------
	// keys
	// ------------------------------------------------------------

	// short random stretches, all under debounce_clks
	task automatic bounce(input int n, input logic settle_level);
		int len;
		for (int i = 0; i < 4; i++) begin
			len = $urandom % (debounce_clks / 2) + 1;
			@(posedge clk27);
			key[n] <= settle_level;
			repeat (len) @(posedge clk27);
			key[n] <= ~settle_level;
			repeat (len) @(posedge clk27);
		end
		key[n] <= settle_level;
	endtask

	task automatic press_key(input int n, input logic [1:0] exp);
		bounce(n, 1'b0);
		repeat (3 * debounce_clks) @(posedge clk27);
		// key 0 held, request on and led lit
		if (n == 0) begin
			@(negedge clk27);
			checks++;
			if (reset_request !== 1'b1 || led[1] !== 1'b0) begin
				errors++;
				$display("MISMATCH key0 hold expected %b actual %b", 2'b10,
					{reset_request, led[1]});
			end
		end
		bounce(n, 1'b1);
		repeat (3 * debounce_clks) @(posedge clk27);
		@(negedge clk27);
		checks++;
		if (led[2:1] !== exp || reset_request !== 1'b0) begin
			errors++;
			$display("MISMATCH key%0d press expected %b actual %b", n, {1'b0, exp},
				{reset_request, led[2:1]});
		end
	endtask

	// ------------------------------------------------------------
	// decoder, mid-bit samples on the falling clock edge
	// ------------------------------------------------------------
	initial begin : decoder
		logic [7:0] shift;
		logic prev;
		prev = 1'b1;
		wait (rst === 1'b0);
		forever begin
			@(negedge clk27);
			if (prev && !serial_tx) begin
				repeat (clks_per_bit / 2) @(negedge clk27);
				if (serial_tx !== 1'b0) begin
					errors++;
					$display("start bit on serial_tx did not hold low");
				end
				for (int i = 0; i < 8; i++) begin
					repeat (clks_per_bit) @(negedge clk27);
					shift = {serial_tx, shift[7:1]};
				end
				repeat (clks_per_bit) @(negedge clk27);
				if (serial_tx !== 1'b1) begin
					errors++;
					$display("stop bit on serial_tx was low");
				end
				rx_q.push_back(shift);
			end
			prev = serial_tx;
		end
	end

	// budget per record, two times 13 chars plus debounce time
	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = 2 * (n_rec + 1) * (13 * 10 * clks_per_bit + 16 * debounce_clks);
		repeat (limit) @(posedge clk27);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("Finished with errors");
		$finish;
	end

	initial begin : main
		int fd;
		int code;
		int ch;
		int unsigned first_draw;
		logic [7:0] kind;
		logic [7:0] a;
		logic [7:0] b;
		bit idle_bad;
		bit ok;
		first_draw = $urandom(32'h93eb);
		rst = 1'b1;
		serial_rx = 1'b1;
		key = 2'b11;
		idle_bad = 1'b0;

		// records, # lines are comments
		fd = $fopen("echo_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open echo_stimulus.txt");
		end else begin
			while (!$feof(fd) && n_rec < 32) begin
				code = $fscanf(fd, " %c", kind);
				if (code == 1 && kind == "#") begin
					ch = 0;
					while (ch != "\n" && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else if (code == 1) begin
					code = $fscanf(fd, " %h %h", a, b);
					kinds[n_rec] = kind;
					arg_a[n_rec] = a;
					arg_b[n_rec] = b;
					n_rec++;
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;

		repeat (5) @(posedge clk27);
		rst <= 1'b0;

		// quiet line and dark leds after reset
		for (int i = 0; i < 20 * clks_per_bit; i++) begin
			@(negedge clk27);
			if (serial_tx !== 1'b1) idle_bad = 1'b1;
		end
		checks++;
		if (idle_bad) begin
			errors++;
			$display("serial_tx left the idle level with no stimulus");
		end
		checks++;
		if (led !== 6'b111111 || reset_request !== 1'b0) begin
			errors++;
			$display("MISMATCH reset leds expected %b actual %b", 7'b0111111,
				{reset_request, led});
		end

		for (int r = 0; r < n_rec; r++) begin
			case (kinds[r])
				"c": begin
					idle_bits(arg_b[r]);
					send_serial_char(arg_a[r]);
					check_reply(arg_a[r], $sformatf("char_%h", arg_a[r]));
				end
				"o": begin
					// second char lands mid reply and must vanish
					send_serial_char(arg_a[r]);
					wait_for_chars(1, ok);
					send_serial_char(arg_b[r]);
					check_reply(arg_a[r], $sformatf("overlap_%h", arg_a[r]));
					idle_bits(20);
					checks++;
					if (rx_q.size() != 0) begin
						errors++;
						$display("a character sent during a reply was echoed");
					end
				end
				"k": press_key(arg_a[r], arg_b[r][1:0]);
				default: begin
					errors++;
					$display("unknown record kind in stimulus file at record %0d", r);
				end
			endcase
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: uart_rx.sv
// 8N1 receiver; a start edge is accepted only while enable is high, framing errors drop the char
`timescale 1ns/1ps
`default_nettype none

module uart_rx import echo_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic enable,
	input logic serial_rx,
	output logic [char_bits-1:0] char,
	output logic word_finished
);

	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	rx_state_t state;
	logic [1:0] sync;
	logic line;
	logic line_prev;
	logic [baud_cnt_w-1:0] acc;
	logic [baud_cnt_w:0] acc_sum;
	logic tick;
	logic [tick_w-1:0] tick_cnt;
	logic sample_now;
	logic bit_done;
	logic [char_idx_w-1:0] bit_idx;
	logic [char_bits-1:0] shreg;

	assign line = sync[1];

	// fractional tick generator, oversample ticks per clks_per_bit on average
	assign acc_sum = {1'b0, acc} + (baud_cnt_w + 1)'(oversample);
	assign tick = acc_sum >= (baud_cnt_w + 1)'(clks_per_bit);

	// middle of bit and end of bit
	assign sample_now = tick && tick_cnt == tick_w'(sample_point - 1);
	assign bit_done = tick && tick_cnt == tick_w'(oversample - 1);

	// two-flop sync, line idles high
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			sync <= 2'b11;
			line_prev <= 1'b1;
		end else begin
			sync <= {sync[0], serial_rx};
			line_prev <= line;
		end
	end

	// ------------------------------------------------------------
	// frame fsm
	// ------------------------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state <= rx_idle;
			acc <= '0;
			tick_cnt <= '0;
			bit_idx <= '0;
			word_finished <= 1'b0;
		end else begin
			word_finished <= 1'b0;
			if (state != rx_idle) begin
				acc <= tick ? baud_cnt_w'(acc_sum - (baud_cnt_w + 1)'(clks_per_bit))
					: acc_sum[baud_cnt_w-1:0];
				if (tick) begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
			case (state)
				rx_idle: begin
					// falling edge starts a frame
					if (enable && line_prev && !line) begin
						state <= rx_start;
						acc <= '0;
						tick_cnt <= '0;
					end
				end
				rx_start: begin
					// glitch, not a real start bit
					if (sample_now && line) begin
						state <= rx_idle;
					end else if (bit_done) begin
						state <= rx_data;
						bit_idx <= '0;
					end
				end
				rx_data: begin
					if (bit_done) begin
						if (bit_idx == char_idx_w'(char_bits - 1)) begin
							state <= rx_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				rx_stop: begin
					// done at mid stop bit, pulse only on a good stop
					if (sample_now) begin
						state <= rx_idle;
						word_finished <= line;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// data path, lsb arrives first
	always_ff @(posedge clk27) begin
		if (state == rx_data && sample_now) begin
			shreg <= {line, shreg[char_bits-1:1]};
		end
		if (state == rx_stop && sample_now && line) begin
			char <= shreg;
		end
	end

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 transmitter, lsb first; word_finished pulses in the last stop-bit cycle
`timescale 1ns/1ps
`default_nettype none

module uart_tx import echo_pkg::*; (
	input logic clk27,
	input logic rst,
	char_link_if.sink link,
	output logic serial_tx
);

	logic busy;
	logic load;
	logic bit_end;
	logic [baud_cnt_w-1:0] baud_cnt;
	logic [frame_idx_w-1:0] bit_cnt;
	logic [frame_idx_w-1:0] next_idx;
	logic [frame_bits-1:0] frame;

	// idle means ready for the next character
	assign link.ready = ~busy;
	assign load = link.enable && !busy;
	assign bit_end = baud_cnt == baud_cnt_w'(clks_per_bit - 1);
	assign next_idx = bit_cnt + 1'b1;

	// frame: stop, data lsb first, start at bit 0
	always_ff @(posedge clk27) begin
		if (load) begin
			frame <= {1'b1, link.data, 1'b0};
		end
	end

	// ------------------------------------------------------------
	// bit timing and line drive
	// ------------------------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			serial_tx <= 1'b1;
			link.word_finished <= 1'b0;
		end else begin
			// one cycle early so the pulse lands on the last stop cycle
			link.word_finished <= busy && bit_cnt == frame_idx_w'(frame_bits - 1)
				&& baud_cnt == baud_cnt_w'(clks_per_bit - 2);
			if (load) begin
				// start bit goes out next cycle
				busy <= 1'b1;
				baud_cnt <= '0;
				bit_cnt <= '0;
				serial_tx <= 1'b0;
			end else if (busy) begin
				if (bit_end) begin
					baud_cnt <= '0;
					if (bit_cnt == frame_idx_w'(frame_bits - 1)) begin
						// stop bit done, line stays high
						busy <= 1'b0;
						serial_tx <= 1'b1;
					end else begin
						bit_cnt <= next_idx;
						serial_tx <= frame[next_idx];
					end
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire
